//--- Makefile
SIM    := verilator
FLAGS  := --binary --timing --assert -Wno-fatal
TOP    := tb_l2cache
FLIST  := flist.f
OBJDIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- flist.f
src/l2cache_pkg.sv
src/l2cache_array_if.sv
src/l2cache_reqbuf.sv
src/l2cache_tagv.sv
src/l2cache_data.sv
src/l2cache_plru.sv
src/l2cache_fsm.sv
src/l2cache.sv
tests/tb_l2cache.sv

//--- src/l2cache.sv
`default_nettype none

module l2cache (
    input  logic                               clk,
    input  logic                               arst_n,
    // icache
    input  logic                               icache_req,
    input  logic [l2cache_pkg::ADDR_W-1:0]     icache_addr,
    output logic                               icache_addr_ok,
    output logic                               icache_data_ok,
    output logic [l2cache_pkg::L1_LINE_W-1:0]  icache_rdata,
    // dcache
    input  logic                               dcache_req,
    input  logic                               dcache_wr,
    input  logic [l2cache_pkg::ADDR_W-1:0]     dcache_addr,
    input  logic [l2cache_pkg::WORD_W-1:0]     dcache_wdata,
    input  logic [l2cache_pkg::STRB_W-1:0]     dcache_wstrb,
    output logic                               dcache_addr_ok,
    output logic                               dcache_data_ok,
    output logic [l2cache_pkg::L1_LINE_W-1:0]  dcache_rdata,
    // memory
    output logic                               mem_req_r,
    output logic [l2cache_pkg::ADDR_W-1:0]     mem_addr_r,
    input  logic                               mem_addr_ok_r,
    input  logic                               mem_data_ok,
    input  logic [l2cache_pkg::LINE_W-1:0]     mem_rdata,
    output logic                               mem_req_w,
    output logic [l2cache_pkg::ADDR_W-1:0]     mem_addr_w,
    output logic [l2cache_pkg::LINE_W-1:0]     mem_wdata,
    input  logic                               mem_addr_ok_w
);
    import l2cache_pkg::*;

    logic                 accept;
    logic                 req_valid;
    l2_addr_u             buf_addr;
    req_src_e             buf_src;
    logic [WORD_W-1:0]    buf_wdata;
    logic [STRB_W-1:0]    buf_wstrb;
    logic [L1_LINE_W-1:0] l1_rdata;

    l2cache_array_if arr ();

    l2cache_reqbuf u_reqbuf (.*);
    l2cache_fsm    u_fsm    (.*);
    l2cache_tagv   u_tagv   (.*);
    l2cache_data   u_data   (.*);
    l2cache_plru   u_plru   (.*);

    // both L1 ports see the same half-line
    assign icache_rdata = l1_rdata;
    assign dcache_rdata = l1_rdata;

endmodule

`default_nettype wire

//--- src/l2cache_array_if.sv
`default_nettype none

interface l2cache_array_if;
    import l2cache_pkg::*;

    // lookup
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    cmp_tag;
    logic [WAYS-1:0]     hit;
    logic [WAYS-1:0]     valid;
    logic                victim_dirty;
    logic [TAG_W-1:0]    victim_tag;
    logic [WAY_W-1:0]    victim;
    logic [LINE_W-1:0]   rd_line;

    // writes
    logic                refill_we;
    logic                word_we;
    logic [WAY_W-1:0]    wr_way;
    logic [OFFSET_W-1:0] offset;
    logic [WORD_W-1:0]   wdata;
    logic [STRB_W-1:0]   wstrb;
    logic [LINE_W-1:0]   refill_line;

    // replacement update
    logic                use_en;
    logic [WAY_W-1:0]    use_way;

    modport ctrl (
        output index, cmp_tag, refill_we, word_we, wr_way, offset, wdata, wstrb,
        output refill_line, use_en, use_way,
        input  hit, victim_dirty, victim_tag, victim, rd_line
    );
    modport tagv (
        input  index, cmp_tag, refill_we, word_we, wr_way, victim,
        output hit, valid, victim_dirty, victim_tag
    );
    modport data (
        input  index, hit, victim, refill_we, word_we, wr_way, offset, wdata, wstrb,
        input  refill_line,
        output rd_line
    );
    modport repl (
        input  index, valid, use_en, use_way,
        output victim
    );

endinterface

`default_nettype wire

//--- src/l2cache_data.sv
`default_nettype none

module l2cache_data (
    input  logic          clk,
    l2cache_array_if.data arr
);
    import l2cache_pkg::*;

    logic [WORDS-1:0][WORD_W-1:0] lines [SETS][WAYS];
    logic [LINE_W-1:0]            rd_q [WAYS];
    logic [WAY_W-1:0]             rd_way;

    always_ff @(posedge clk) begin
        if (arr.refill_we) begin
            lines[arr.index][arr.wr_way] <= arr.refill_line;
        end else if (arr.word_we) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (arr.wstrb[b]) begin
                    lines[arr.index][arr.wr_way][arr.offset][b*8 +: 8] <= arr.wdata[b*8 +: 8];
                end
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            rd_q[w] <= lines[arr.index][w];
        end
    end

    // hit way if any, victim otherwise
    always_comb begin
        rd_way = arr.victim;
        for (int w = 0; w < WAYS; w++) begin
            if (arr.hit[w]) begin
                rd_way = WAY_W'(w);
            end
        end
    end

    assign arr.rd_line = rd_q[rd_way];

endmodule

`default_nettype wire

//--- src/l2cache_fsm.sv
`default_nettype none

module l2cache_fsm (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               req_valid,
    input  l2cache_pkg::l2_addr_u              buf_addr,
    input  l2cache_pkg::req_src_e              buf_src,
    input  logic [l2cache_pkg::WORD_W-1:0]     buf_wdata,
    input  logic [l2cache_pkg::STRB_W-1:0]     buf_wstrb,
    input  logic                               mem_addr_ok_r,
    input  logic                               mem_addr_ok_w,
    input  logic                               mem_data_ok,
    input  logic [l2cache_pkg::LINE_W-1:0]     mem_rdata,
    output logic                               accept,
    output logic                               icache_data_ok,
    output logic                               dcache_data_ok,
    output logic [l2cache_pkg::L1_LINE_W-1:0]  l1_rdata,
    output logic                               mem_req_r,
    output logic [l2cache_pkg::ADDR_W-1:0]     mem_addr_r,
    output logic                               mem_req_w,
    output logic [l2cache_pkg::ADDR_W-1:0]     mem_addr_w,
    output logic [l2cache_pkg::LINE_W-1:0]     mem_wdata,
    l2cache_array_if.ctrl                      arr
);
    import l2cache_pkg::*;

    logic [2:0]        state;
    logic [2:0]        state_nxt;
    logic              filled;
    logic [WAY_W-1:0]  vway;
    logic [WAY_W-1:0]  hit_way;
    logic [WAY_W-1:0]  way_sel;
    logic [LINE_W-1:0] refill_q;
    logic [LINE_W-1:0] line;
    logic              any_hit;
    logic              done;
    l2_addr_u          addr_r;
    l2_addr_u          addr_w;

    assign any_hit = |arr.hit;
    assign done    = (state == ST_RESP) && (filled || any_hit);
    assign accept  = (state == ST_IDLE) && req_valid;

    assign icache_data_ok = done && (buf_src == SRC_IREAD);
    assign dcache_data_ok = done && (buf_src == SRC_DREAD || buf_src == SRC_DWRITE);

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (arr.hit[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    // after a refill the stored line is the victim way
    assign way_sel = (state == ST_RESP && !filled) ? hit_way : vway;

    assign arr.index       = buf_addr.f.index;
    assign arr.cmp_tag     = buf_addr.f.tag;
    assign arr.offset      = buf_addr.f.offset;
    assign arr.wdata       = buf_wdata;
    assign arr.wstrb       = buf_wstrb;
    assign arr.refill_line = mem_rdata;
    assign arr.refill_we   = (state == ST_RF_WAIT) && mem_data_ok;
    assign arr.word_we     = done && (buf_src == SRC_DWRITE);
    assign arr.wr_way      = way_sel;
    assign arr.use_en      = done;
    assign arr.use_way     = way_sel;

    // line-aligned addresses; write-back goes to the victim's tag
    always_comb begin
        addr_r              = buf_addr;
        addr_r.f.offset     = '0;
        addr_r.f.byte_off   = '0;
        addr_w              = addr_r;
        addr_w.f.tag        = arr.victim_tag;
    end

    assign mem_addr_r = addr_r.raw;
    assign mem_addr_w = addr_w.raw;
    assign mem_wdata  = arr.rd_line;
    assign mem_req_r  = (state == ST_RF_REQ);
    assign mem_req_w  = (state == ST_WB);

    assign line     = filled ? refill_q : arr.rd_line;
    assign l1_rdata = buf_addr.f.offset[OFFSET_W-1] ? line[LINE_W-1 -: L1_LINE_W]
                                                    : line[L1_LINE_W-1:0];

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:    if (accept) state_nxt = ST_LOOKUP;
            ST_LOOKUP:  state_nxt = ST_RESP;
            ST_RESP: begin
                if (done) begin
                    state_nxt = ST_IDLE;
                end else begin
                    state_nxt = arr.victim_dirty ? ST_WB : ST_RF_REQ;
                end
            end
            ST_WB:      if (mem_addr_ok_w) state_nxt = ST_RF_REQ;
            ST_RF_REQ:  if (mem_addr_ok_r) state_nxt = ST_RF_WAIT;
            ST_RF_WAIT: if (mem_data_ok) state_nxt = ST_RESP;
            default:    state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ST_IDLE;
            filled <= 1'b0;
            vway   <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                filled <= 1'b0;
            end else if (arr.refill_we) begin
                filled <= 1'b1;
            end
            // victim fixed at the miss decision
            if (state == ST_RESP && !done) begin
                vway <= arr.victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr.refill_we) begin
            refill_q <= mem_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_req_r && mem_req_w));

endmodule

`default_nettype wire

//--- src/l2cache_pkg.sv
`default_nettype none

package l2cache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int STRB_W     = WORD_W / 8;
    localparam int BYTE_OFF_W = $clog2(STRB_W);
    localparam int OFFSET_W   = 3;
    localparam int WORDS      = 1 << OFFSET_W;
    localparam int INDEX_W    = 2;
    localparam int SETS       = 1 << INDEX_W;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;
    localparam int WAYS       = 4;
    localparam int WAY_W      = $clog2(WAYS);
    localparam int LINE_W     = WORDS * WORD_W;
    localparam int L1_LINE_W  = LINE_W / 2;

    // controller states
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_LOOKUP  = 3'd1;
    localparam logic [2:0] ST_WB      = 3'd2;
    localparam logic [2:0] ST_RF_REQ  = 3'd3;
    localparam logic [2:0] ST_RF_WAIT = 3'd4;
    localparam logic [2:0] ST_RESP    = 3'd5;

    // one address, seen whole by the memory port and as fields by the arrays
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]      tag;
            logic [INDEX_W-1:0]    index;
            logic [OFFSET_W-1:0]   offset;
            logic [BYTE_OFF_W-1:0] byte_off;
        } f;
    } l2_addr_u;

    typedef enum logic [1:0] {
        SRC_NONE   = 2'd0,
        SRC_IREAD  = 2'd1,
        SRC_DREAD  = 2'd2,
        SRC_DWRITE = 2'd3
    } req_src_e;

endpackage

`default_nettype wire

//--- src/l2cache_plru.sv
`default_nettype none

module l2cache_plru (
    input  logic          clk,
    input  logic          arst_n,
    l2cache_array_if.repl arr
);
    import l2cache_pkg::*;

    // bit 0 picks the half, bit 1 ways 0/1, bit 2 ways 2/3
    logic [SETS-1:0][WAYS-2:0] tree;
    logic [WAYS-2:0]           cur;

    assign cur = tree[arr.index];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tree <= '0;
        end else if (arr.use_en) begin
            tree[arr.index][0] <= ~arr.use_way[1];
            if (arr.use_way[1]) begin
                tree[arr.index][2] <= ~arr.use_way[0];
            end else begin
                tree[arr.index][1] <= ~arr.use_way[0];
            end
        end
    end

    always_comb begin
        arr.victim = {cur[0], cur[0] ? cur[2] : cur[1]};
        // lowest invalid way overrides the tree
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!arr.valid[w]) begin
                arr.victim = WAY_W'(w);
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        (arr.victim < WAYS) && ((&arr.valid) || !arr.valid[arr.victim]));

endmodule

`default_nettype wire

//--- src/l2cache_reqbuf.sv
`default_nettype none

module l2cache_reqbuf (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               icache_req,
    input  logic [l2cache_pkg::ADDR_W-1:0]     icache_addr,
    input  logic                               dcache_req,
    input  logic                               dcache_wr,
    input  logic [l2cache_pkg::ADDR_W-1:0]     dcache_addr,
    input  logic [l2cache_pkg::WORD_W-1:0]     dcache_wdata,
    input  logic [l2cache_pkg::STRB_W-1:0]     dcache_wstrb,
    input  logic                               accept,
    output logic                               icache_addr_ok,
    output logic                               dcache_addr_ok,
    output logic                               req_valid,
    output l2cache_pkg::l2_addr_u              buf_addr,
    output l2cache_pkg::req_src_e              buf_src,
    output logic [l2cache_pkg::WORD_W-1:0]     buf_wdata,
    output logic [l2cache_pkg::STRB_W-1:0]     buf_wstrb
);
    import l2cache_pkg::*;

    req_src_e src_nxt;

    assign req_valid = icache_req || dcache_req;

    // dcache wins a tie
    assign dcache_addr_ok = accept && dcache_req;
    assign icache_addr_ok = accept && icache_req && !dcache_req;

    always_comb begin
        if (dcache_req) begin
            src_nxt = dcache_wr ? SRC_DWRITE : SRC_DREAD;
        end else begin
            src_nxt = SRC_IREAD;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_src <= SRC_NONE;
        end else if (accept) begin
            buf_src <= src_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr.raw <= dcache_req ? dcache_addr : icache_addr;
            buf_wdata    <= dcache_wdata;
            buf_wstrb    <= dcache_wstrb;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        !(icache_addr_ok && dcache_addr_ok));

endmodule

`default_nettype wire

//--- src/l2cache_tagv.sv
`default_nettype none

module l2cache_tagv (
    input  logic          clk,
    input  logic          arst_n,
    l2cache_array_if.tagv arr
);
    import l2cache_pkg::*;

    logic [TAG_W-1:0]            tags [SETS][WAYS];
    logic [SETS-1:0][WAYS-1:0]   valid;
    logic [SETS-1:0][WAYS-1:0]   dirty;
    logic [TAG_W-1:0]            tag_q [WAYS];
    logic [WAYS-1:0]             valid_q;
    logic [WAYS-1:0]             dirty_q;

    always_ff @(posedge clk) begin
        if (arr.refill_we) begin
            tags[arr.index][arr.wr_way] <= arr.cmp_tag;
        end
        for (int w = 0; w < WAYS; w++) begin
            tag_q[w] <= tags[arr.index][w];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid   <= '0;
            dirty   <= '0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (arr.refill_we) begin
                valid[arr.index][arr.wr_way] <= 1'b1;
                dirty[arr.index][arr.wr_way] <= 1'b0;
            end else if (arr.word_we) begin
                dirty[arr.index][arr.wr_way] <= 1'b1;
            end
            valid_q <= valid[arr.index];
            dirty_q <= dirty[arr.index];
        end
    end

    // compare in all ways
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            arr.hit[w] = valid_q[w] && (tag_q[w] == arr.cmp_tag);
        end
    end

    assign arr.valid        = valid_q;
    assign arr.victim_dirty = valid_q[arr.victim] && dirty_q[arr.victim];
    assign arr.victim_tag   = tag_q[arr.victim];

    // a line is never refilled into a set that already holds it
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(arr.hit));

endmodule

`default_nettype wire

//--- tests/tb_l2cache.sv
`default_nettype none

module tb_l2cache;
    import l2cache_pkg::*;

    localparam int          CLK_PERIOD = 20;
    localparam int          DRV        = 2;
    localparam logic [31:0] SEED       = 32'h0752fe5a;
    localparam int          N_RAND     = 300;
    // 32 working lines, then 32 more that only the final sweep touches
    localparam int          N_LINES    = 64;
    localparam int          MEM_WORDS  = N_LINES * WORDS;
    localparam int          N_OPS      = 2 * N_RAND + N_LINES / 2 + 8;

    logic                 clk;
    logic                 arst_n;
    logic                 icache_req;
    logic [ADDR_W-1:0]    icache_addr;
    logic                 icache_addr_ok;
    logic                 icache_data_ok;
    logic [L1_LINE_W-1:0] icache_rdata;
    logic                 dcache_req;
    logic                 dcache_wr;
    logic [ADDR_W-1:0]    dcache_addr;
    logic [WORD_W-1:0]    dcache_wdata;
    logic [STRB_W-1:0]    dcache_wstrb;
    logic                 dcache_addr_ok;
    logic                 dcache_data_ok;
    logic [L1_LINE_W-1:0] dcache_rdata;
    logic                 mem_req_r;
    logic [ADDR_W-1:0]    mem_addr_r;
    logic                 mem_addr_ok_r;
    logic                 mem_data_ok;
    logic [LINE_W-1:0]    mem_rdata;
    logic                 mem_req_w;
    logic [ADDR_W-1:0]    mem_addr_w;
    logic [LINE_W-1:0]    mem_wdata;
    logic                 mem_addr_ok_w;

    logic [WORD_W-1:0] mem_words [MEM_WORDS];
    logic [WORD_W-1:0] ref_words [MEM_WORDS];
    // lines written since their last write-back
    logic [N_LINES-1:0] dirty_lines;
    // request in flight
    logic [ADDR_W-1:0] cur_addr;
    int                cyc = 0;
    int                mem_reqs = 0;

    l2cache UUT (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (mem_req_r || mem_req_w) begin
            mem_reqs <= mem_reqs + 1;
        end
    end

    task automatic check(input string name, input logic [LINE_W-1:0] actual,
                         input logic [LINE_W-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: actual %0h expected %0h", $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [L1_LINE_W-1:0] ref_half(input logic [ADDR_W-1:0] addr);
        int                   base;
        logic [L1_LINE_W-1:0] half;
        base = int'(addr[10:4]) * 4;
        for (int k = 0; k < 4; k++) begin
            half[k*WORD_W +: WORD_W] = ref_words[base + k];
        end
        return half;
    endfunction

    // memory side, posted write applied when accepted
    task automatic serve_write();
        int base;
        int line_n;
        repeat ($urandom_range(0, 3)) begin
            @(posedge clk);
            #DRV;
        end
        // victim shares the set of the request in flight
        check("mem_addr_w", {mem_addr_w[31:11], mem_addr_w[6:0]},
              {21'b0, cur_addr[6:5], 5'b0});
        line_n = int'(mem_addr_w[10:5]);
        check("dirty flag of the written-back line", dirty_lines[line_n], 1'b1);
        dirty_lines[line_n] = 1'b0;
        base = line_n * WORDS;
        for (int k = 0; k < WORDS; k++) begin
            mem_words[base + k] = mem_wdata[k*WORD_W +: WORD_W];
        end
        mem_addr_ok_w = 1'b1;
    endtask

    task automatic serve_read();
        int base;
        repeat ($urandom_range(0, 3)) begin
            @(posedge clk);
            #DRV;
        end
        check("mem_addr_r", mem_addr_r, {cur_addr[ADDR_W-1:5], 5'b0});
        base = int'(mem_addr_r[10:5]) * WORDS;
        mem_addr_ok_r = 1'b1;
        repeat ($urandom_range(1, 4)) begin
            @(posedge clk);
            #DRV;
            mem_addr_ok_r = 1'b0;
        end
        for (int k = 0; k < WORDS; k++) begin
            mem_rdata[k*WORD_W +: WORD_W] = mem_words[base + k];
        end
        mem_data_ok = 1'b1;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #DRV;
            mem_addr_ok_r = 1'b0;
            mem_addr_ok_w = 1'b0;
            mem_data_ok   = 1'b0;
            if (mem_req_w) begin
                serve_write();
            end else if (mem_req_r) begin
                serve_read();
            end
        end
    end

    // one request, starting and ending just after a rising edge
    task automatic access(input logic dport, input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [WORD_W-1:0] wdata, input logic [STRB_W-1:0] wstrb,
                          output int lat, output int reqs);
        int t0;
        int r0;
        cur_addr = addr;
        if (dport) begin
            dcache_req   = 1'b1;
            dcache_wr    = wr;
            dcache_addr  = addr;
            dcache_wdata = wdata;
            dcache_wstrb = wstrb;
        end else begin
            icache_req  = 1'b1;
            icache_addr = addr;
        end
        @(negedge clk);
        while (!(dport ? dcache_addr_ok : icache_addr_ok)) begin
            @(negedge clk);
        end
        t0 = cyc;
        r0 = mem_reqs;
        @(posedge clk);
        #DRV;
        dcache_req = 1'b0;
        icache_req = 1'b0;
        @(negedge clk);
        while (!(dport ? dcache_data_ok : icache_data_ok)) begin
            @(negedge clk);
        end
        check(dport ? "icache_data_ok" : "dcache_data_ok",
              dport ? icache_data_ok : dcache_data_ok, '0);
        lat  = cyc - t0;
        reqs = mem_reqs - r0;
        if (wr) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb[b]) begin
                    ref_words[addr[10:2]][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            dirty_lines[addr[10:5]] = 1'b1;
        end else begin
            check(dport ? "dcache_rdata" : "icache_rdata",
                  dport ? dcache_rdata : icache_rdata, ref_half(addr));
        end
        @(posedge clk);
        #DRV;
    endtask

    initial begin : stimulus
        logic [ADDR_W-1:0] addr;
        int                line_n;
        int                lat;
        int                reqs;
        void'($urandom(SEED));
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_words[w] = (32'(w) * 32'h9e37_79b9) ^ {16'h5a3c, 16'(w)};
            ref_words[w] = mem_words[w];
        end
        dirty_lines   = '0;
        cur_addr      = '0;
        arst_n        = 1'b0;
        icache_req    = 1'b0;
        icache_addr   = '0;
        dcache_req    = 1'b0;
        dcache_wr     = 1'b0;
        dcache_addr   = '0;
        dcache_wdata  = '0;
        dcache_wstrb  = '0;
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        repeat (3) @(posedge clk);
        #DRV;
        arst_n = 1'b1;

        // quiet until the first request
        repeat (4) begin
            @(negedge clk);
            check("{addr_ok, data_ok, mem_req}", {icache_addr_ok, icache_data_ok,
                  dcache_addr_ok, dcache_data_ok, mem_req_r, mem_req_w}, '0);
        end
        @(posedge clk);
        #DRV;

        for (int i = 0; i < N_RAND; i++) begin
            line_n = $urandom_range(0, 31);
            // crowd set 1 to force evictions
            if ($urandom_range(0, 2) == 0) begin
                line_n = (line_n & ~3) | 1;
            end
            addr = ADDR_W'(line_n * 32 + $urandom_range(0, 7) * 4);
            case ($urandom_range(0, 2))
                0:       access(1'b0, 1'b0, addr, '0, '0, lat, reqs);
                1:       access(1'b1, 1'b0, addr, '0, '0, lat, reqs);
                default: access(1'b1, 1'b1, addr, $urandom, STRB_W'($urandom_range(1, 15)),
                                lat, reqs);
            endcase
            if ($urandom_range(0, 3) == 0) begin
                addr[4:2] = 3'($urandom_range(0, 7));
                access(1'($urandom_range(0, 1)), 1'b0, addr, '0, '0, lat, reqs);
                check("data_ok latency on hit", lat, 2);
                check("memory requests during hit", reqs, 0);
            end
            repeat ($urandom_range(0, 2)) begin
                @(posedge clk);
                #DRV;
            end
        end

        // both ports at once
        cur_addr    = 32'h0000_0040;
        dcache_req  = 1'b1;
        dcache_wr   = 1'b0;
        dcache_addr = 32'h0000_0040;
        icache_req  = 1'b1;
        icache_addr = 32'h0000_0110;
        @(negedge clk);
        check("dcache_addr_ok", dcache_addr_ok, 1'b1);
        check("icache_addr_ok", icache_addr_ok, 1'b0);
        @(posedge clk);
        #DRV;
        dcache_req = 1'b0;
        @(negedge clk);
        while (!dcache_data_ok) begin
            check("icache_addr_ok", icache_addr_ok, 1'b0);
            @(negedge clk);
        end
        check("icache_addr_ok", icache_addr_ok, 1'b0);
        check("dcache_rdata", dcache_rdata, ref_half(32'h0000_0040));
        @(posedge clk);
        #DRV;
        access(1'b0, 1'b0, 32'h0000_0110, '0, '0, lat, reqs);

        // eight fresh lines per set push every dirty line out
        for (int l = 32; l < N_LINES; l++) begin
            access(1'b1, 1'b0, ADDR_W'(l * 32), '0, '0, lat, reqs);
        end
        check("lines never written back", dirty_lines, '0);
        for (int w = 0; w < MEM_WORDS; w++) begin
            check($sformatf("mem_words[%0d]", w), mem_words[w], ref_words[w]);
        end
        $display("test passed");
        $finish;
    end

    initial begin
        #(N_OPS * 60 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a handshake never completed", N_OPS * 60);
        $display("test failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
